// ==== Bender.yml ====
package:
  name: exu_ecl

sources:
  - hw/exu_pkg.sv
  - hw/issue_if.sv
  - hw/wb_if.sv
  - hw/exu_dispatch.sv
  - hw/exu_bypass.sv
  - hw/exu_execute.sv
  - hw/exu_writeback.sv
  - hw/exu_ecl.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_exu_ecl.sv

// ==== filelist.f ====
+incdir+verif
hw/exu_pkg.sv
hw/issue_if.sv
hw/wb_if.sv
hw/exu_dispatch.sv
hw/exu_bypass.sv
hw/exu_execute.sv
hw/exu_writeback.sv
hw/exu_ecl.sv
verif/tb_exu_ecl.sv

// ==== hw/exu_bypass.sv ====
module exu_bypass import exu_pkg::*; #(
   parameter int grlen = 32
) (
   issue_if.bypass          issue,
   wb_if.bypass             wb,
   output logic [grlen-1:0] opa_e,
   output logic [grlen-1:0] opb_e
);

   logic a_hit_m;
   logic a_hit_w;
   logic b_hit_m;
   logic b_hit_w;

   // register match against a later stage, r0 never forwarded
   function automatic logic fwd_hit(
      input logic      sel_rf,
      input reg_addr_t rs,
      input logic      wen,
      input reg_addr_t rd
   );
      return sel_rf && (rs != '0) && wen && (rd == rs);
   endfunction

   //////////////////////////////////////////////////
   // operand a
   //////////////////////////////////////////////////

   assign a_hit_m = fwd_hit(issue.a_sel_rf_e, issue.rs1_e, wb.wen_m, wb.rd_m);
   assign a_hit_w = fwd_hit(issue.a_sel_rf_e, issue.rs1_e, wb.wen_w, wb.rd_w);

   // youngest result first
   assign opa_e = a_hit_m ? wb.data_m :
                  a_hit_w ? wb.data_w : issue.alu_a_e;

   //////////////////////////////////////////////////
   // operand b
   //////////////////////////////////////////////////

   assign b_hit_m = fwd_hit(issue.b_sel_rf_e, issue.rs2_e, wb.wen_m, wb.rd_m);
   assign b_hit_w = fwd_hit(issue.b_sel_rf_e, issue.rs2_e, wb.wen_w, wb.rd_w);

   assign opb_e = b_hit_m ? wb.data_m :
                  b_hit_w ? wb.data_w : issue.alu_b_e;

endmodule

// ==== hw/exu_dispatch.sv ====
module exu_dispatch import exu_pkg::*; #(
   parameter int grlen = 32
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             valid_d,
   input  logic             kill_d,
   input  inst_t            inst_d,
   input  logic [grlen-1:0] pc_d,
   input  logic [grlen-1:0] imm_d,
   input  logic [grlen-1:0] c_d,
   input  logic [grlen-1:0] br_offs_d,
   input  logic [grlen-1:0] rs1_data_d,
   input  logic [grlen-1:0] rs2_data_d,
   input  alu_code_t        alu_code_d,
   input  bru_code_t        bru_code_d,
   input  mdu_code_t        mdu_code_d,
   input  logic             is_bru_d,
   input  logic             is_mul_d,
   input  logic             a_pc_d,
   input  logic             b_imm_d,
   input  logic             rd2rj_d,
   input  logic             rd_read_d,
   input  logic             double_word_d,
   input  logic             rf_wen_d,
   input  reg_addr_t        rf_target_d,
   output reg_addr_t        rs1_d,
   output reg_addr_t        rs2_d,
   issue_if.dispatch        issue
);

   logic             inst_vld_d;
   logic             alu_d;
   logic             b_imm_alu_d;
   logic [grlen-1:0] alu_a_d;
   logic [grlen-1:0] alu_b_d;
   logic             mul_signed_d;
   logic             mul_double_d;
   logic             mul_hi_d;
   logic             mul_short_d;

   // a taken branch in E drops whatever sits in D
   assign inst_vld_d = valid_d & ~kill_d;
   assign alu_d      = ~is_bru_d & ~is_mul_d;

   //////////////////////////////////////////////////
   // register file read addresses
   //////////////////////////////////////////////////

   assign rs1_d = rd2rj_d   ? inst_d[field_rd_lsb +: $bits(reg_addr_t)]
                            : inst_d[field_rj_lsb +: $bits(reg_addr_t)];
   assign rs2_d = rd_read_d ? inst_d[field_rd_lsb +: $bits(reg_addr_t)]
                            : inst_d[field_rk_lsb +: $bits(reg_addr_t)];

   // operand select, immediate only for alu ops
   assign b_imm_alu_d = b_imm_d & alu_d;
   assign alu_a_d     = a_pc_d ? pc_d : rs1_data_d;
   assign alu_b_d     = b_imm_alu_d ? imm_d : rs2_data_d;

   //////////////////////////////////////////////////
   // multiplier flags
   //////////////////////////////////////////////////

   assign mul_signed_d = mdu_code_d inside {mdu_mul_w, mdu_mulh_w, mdu_mul_d,
                                            mdu_mulh_d, mdu_mulw_d_w};
   assign mul_double_d = mdu_code_d inside {mdu_mul_d, mdu_mulh_d, mdu_mulh_du};
   assign mul_hi_d     = mdu_code_d inside {mdu_mulh_w, mdu_mulh_wu, mdu_mulh_d,
                                            mdu_mulh_du};
   assign mul_short_d  = mdu_code_d inside {mdu_mul_w, mdu_mulh_w, mdu_mulh_wu};

   //////////////////////////////////////////////////
   // d to e registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         issue.valid_e     <= 1'b0;
         issue.bru_valid_e <= 1'b0;
         issue.mul_valid_e <= 1'b0;
         issue.alu_wen_e   <= 1'b0;
         issue.mul_wen_e   <= 1'b0;
      end else begin
         issue.valid_e     <= inst_vld_d;
         issue.bru_valid_e <= inst_vld_d & is_bru_d;
         issue.mul_valid_e <= inst_vld_d & is_mul_d;
         issue.alu_wen_e   <= inst_vld_d & alu_d & rf_wen_d;
         issue.mul_wen_e   <= inst_vld_d & is_mul_d & rf_wen_d;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      issue.rs1_e         <= rs1_d;
      issue.rs2_e         <= rs2_d;
      issue.a_sel_rf_e    <= ~a_pc_d;
      issue.b_sel_rf_e    <= ~b_imm_alu_d;
      issue.alu_a_e       <= alu_a_d;
      issue.alu_b_e       <= alu_b_d;
      issue.alu_op_e      <= alu_code_d;
      issue.alu_c_e       <= c_d;
      issue.double_word_e <= double_word_d;
      issue.bru_op_e      <= bru_code_d;
      issue.pc_e          <= pc_d;
      issue.br_offs_e     <= br_offs_d;
      issue.signed_e      <= mul_signed_d;
      issue.double_e      <= mul_double_d;
      issue.hi_e          <= mul_hi_d;
      issue.short_e       <= mul_short_d;
      issue.rd_e          <= rf_target_d;
   end

endmodule

// ==== hw/exu_ecl.sv ====
module exu_ecl import exu_pkg::*; #(
   parameter int grlen = 32
) (
   input  logic             clk,
   input  logic             reset,
   // decoded instruction in D
   input  logic             valid_d,
   input  inst_t            inst_d,
   input  logic [grlen-1:0] pc_d,
   input  logic [grlen-1:0] imm_d,
   input  logic [grlen-1:0] c_d,
   input  logic [grlen-1:0] br_offs_d,
   input  alu_code_t        alu_code_d,
   input  bru_code_t        bru_code_d,
   input  mdu_code_t        mdu_code_d,
   input  logic             is_bru_d,
   input  logic             is_mul_d,
   input  logic             a_pc_d,
   input  logic             b_imm_d,
   input  logic             rd2rj_d,
   input  logic             rd_read_d,
   input  logic             double_word_d,
   input  logic             rf_wen_d,
   input  reg_addr_t        rf_target_d,
   // register file reads
   output reg_addr_t        rs1_d,
   output reg_addr_t        rs2_d,
   input  logic [grlen-1:0] rs1_data_d,
   input  logic [grlen-1:0] rs2_data_d,
   // alu
   output logic             alu_valid_e,
   output logic [grlen-1:0] alu_a_e,
   output logic [grlen-1:0] alu_b_e,
   output alu_code_t        alu_op_e,
   output logic [grlen-1:0] alu_c_e,
   output logic             alu_double_word_e,
   input  logic [grlen-1:0] alu_res_e,
   // bru
   output logic             bru_valid_e,
   output bru_code_t        bru_op_e,
   output logic [grlen-1:0] bru_a_e,
   output logic [grlen-1:0] bru_b_e,
   output logic [grlen-1:0] bru_pc_e,
   output logic [grlen-1:0] bru_offset_e,
   input  logic             bru_taken_e,
   input  logic [grlen-1:0] bru_target_e,
   input  logic [grlen-1:0] bru_link_pc_e,
   input  logic             bru_wen_e,
   output logic             br_taken,
   output logic [grlen-1:0] br_target,
   // mul, result returns in M
   output logic             mul_valid_e,
   output logic [grlen-1:0] mul_a_e,
   output logic [grlen-1:0] mul_b_e,
   output logic             mul_signed_e,
   output logic             mul_double_e,
   output logic             mul_hi_e,
   output logic             mul_short_e,
   input  logic [grlen-1:0] mul_res_m,
   // register file write
   output logic [grlen-1:0] irf_rd_data_w,
   output logic             irf_wen_w,
   output reg_addr_t        irf_rd_w
);

   logic             kill_d;
   logic [grlen-1:0] opa_e;
   logic [grlen-1:0] opb_e;
   logic             alu_wen_m;
   logic             bru_wen_m;
   logic             mul_valid_m;
   logic             mul_wen_m;
   reg_addr_t        rd_m_pre;
   logic [grlen-1:0] alu_res_m;
   logic [grlen-1:0] link_pc_m;

   issue_if #(.grlen(grlen)) issue ();
   wb_if    #(.grlen(grlen)) wb ();

   //////////////////////////////////////////////////
   // pipeline stages
   //////////////////////////////////////////////////

   exu_dispatch #(.grlen(grlen)) dispatch_i (
      .issue (issue),
      .*
   );

   exu_bypass #(.grlen(grlen)) bypass_i (
      .issue (issue),
      .wb    (wb),
      .opa_e (opa_e),
      .opb_e (opb_e)
   );

   exu_execute #(.grlen(grlen)) execute_i (
      .issue (issue),
      .*
   );

   exu_writeback #(.grlen(grlen)) writeback_i (
      .wb (wb),
      .*
   );

endmodule

// ==== hw/exu_execute.sv ====
module exu_execute import exu_pkg::*; #(
   parameter int grlen = 32
) (
   input  logic             clk,
   input  logic             reset,
   issue_if.execute         issue,
   input  logic [grlen-1:0] opa_e,
   input  logic [grlen-1:0] opb_e,
   input  logic             bru_taken_e,
   input  logic [grlen-1:0] bru_target_e,
   input  logic [grlen-1:0] bru_link_pc_e,
   input  logic             bru_wen_e,
   input  logic [grlen-1:0] alu_res_e,
   // unit interfaces
   output logic             alu_valid_e,
   output logic [grlen-1:0] alu_a_e,
   output logic [grlen-1:0] alu_b_e,
   output alu_code_t        alu_op_e,
   output logic [grlen-1:0] alu_c_e,
   output logic             alu_double_word_e,
   output logic             bru_valid_e,
   output bru_code_t        bru_op_e,
   output logic [grlen-1:0] bru_a_e,
   output logic [grlen-1:0] bru_b_e,
   output logic [grlen-1:0] bru_pc_e,
   output logic [grlen-1:0] bru_offset_e,
   output logic             mul_valid_e,
   output logic [grlen-1:0] mul_a_e,
   output logic [grlen-1:0] mul_b_e,
   output logic             mul_signed_e,
   output logic             mul_double_e,
   output logic             mul_hi_e,
   output logic             mul_short_e,
   // branch redirect
   output logic             kill_d,
   output logic             br_taken,
   output logic [grlen-1:0] br_target,
   // m stage bundle
   output logic             alu_wen_m,
   output logic             bru_wen_m,
   output logic             mul_valid_m,
   output logic             mul_wen_m,
   output reg_addr_t        rd_m_pre,
   output logic [grlen-1:0] alu_res_m,
   output logic [grlen-1:0] link_pc_m
);

   // same bypassed operands go to every unit
   assign alu_valid_e       = issue.valid_e & ~issue.bru_valid_e & ~issue.mul_valid_e;
   assign alu_a_e           = opa_e;
   assign alu_b_e           = opb_e;
   assign alu_op_e          = issue.alu_op_e;
   assign alu_c_e           = issue.alu_c_e;
   assign alu_double_word_e = issue.double_word_e;

   assign bru_valid_e  = issue.bru_valid_e;
   assign bru_op_e     = issue.bru_op_e;
   assign bru_a_e      = opa_e;
   assign bru_b_e      = opb_e;
   assign bru_pc_e     = issue.pc_e;
   assign bru_offset_e = issue.br_offs_e;

   assign mul_valid_e  = issue.mul_valid_e;
   assign mul_a_e      = opa_e;
   assign mul_b_e      = opb_e;
   assign mul_signed_e = issue.signed_e;
   assign mul_double_e = issue.double_e;
   assign mul_hi_e     = issue.hi_e;
   assign mul_short_e  = issue.short_e;

   //////////////////////////////////////////////////
   // branch resolution
   //////////////////////////////////////////////////

   assign br_taken  = issue.bru_valid_e & bru_taken_e;
   assign br_target = bru_target_e;
   assign kill_d    = br_taken;

   //////////////////////////////////////////////////
   // e to m registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         alu_wen_m   <= 1'b0;
         bru_wen_m   <= 1'b0;
         mul_valid_m <= 1'b0;
         mul_wen_m   <= 1'b0;
      end else begin
         alu_wen_m   <= issue.alu_wen_e;
         bru_wen_m   <= issue.bru_valid_e & bru_wen_e;
         mul_valid_m <= issue.mul_valid_e;
         mul_wen_m   <= issue.mul_wen_e;
      end
   end

   always_ff @(posedge clk) begin
      rd_m_pre  <= issue.rd_e;
      alu_res_m <= alu_res_e;
      link_pc_m <= bru_link_pc_e;
   end

endmodule

// ==== hw/exu_pkg.sv ====
package exu_pkg;

   typedef logic [4:0]  reg_addr_t;
   typedef logic [31:0] inst_t;

   // low bit of each register field in the instruction word
   localparam int field_rd_lsb = 0;
   localparam int field_rj_lsb = 5;
   localparam int field_rk_lsb = 10;

   typedef logic [3:0] alu_code_t;
   typedef logic [3:0] bru_code_t;
   typedef logic [3:0] mdu_code_t;

   // multiplier operation codes
   localparam mdu_code_t mdu_mul_w     = 4'd0;
   localparam mdu_code_t mdu_mulh_w    = 4'd1;
   localparam mdu_code_t mdu_mulh_wu   = 4'd2;
   localparam mdu_code_t mdu_mul_d     = 4'd3;
   localparam mdu_code_t mdu_mulh_d    = 4'd4;
   localparam mdu_code_t mdu_mulh_du   = 4'd5;
   localparam mdu_code_t mdu_mulw_d_w  = 4'd6;
   localparam mdu_code_t mdu_mulw_d_wu = 4'd7;

endpackage

// ==== hw/exu_writeback.sv ====
module exu_writeback import exu_pkg::*; #(
   parameter int grlen = 32
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             alu_wen_m,
   input  logic             bru_wen_m,
   input  logic             mul_valid_m,
   input  logic             mul_wen_m,
   input  reg_addr_t        rd_m_pre,
   input  logic [grlen-1:0] alu_res_m,
   input  logic [grlen-1:0] link_pc_m,
   input  logic [grlen-1:0] mul_res_m,
   wb_if.writeback          wb,
   output logic [grlen-1:0] irf_rd_data_w,
   output logic             irf_wen_w,
   output reg_addr_t        irf_rd_w
);

   //////////////////////////////////////////////////
   // m stage result select
   //////////////////////////////////////////////////

   // all units share the one rd, it follows the instruction down the pipe
   assign wb.rd_m = rd_m_pre;

   // any unit may claim the write
   assign wb.wen_m = alu_wen_m | bru_wen_m | mul_wen_m;

   // alu result is the default when no other unit claims it
   always_comb begin
      if (bru_wen_m) begin
         wb.data_m = link_pc_m;
      end else if (mul_valid_m) begin
         wb.data_m = mul_res_m;
      end else begin
         wb.data_m = alu_res_m;
      end
   end

   //////////////////////////////////////////////////
   // m to w registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wb.wen_w <= 1'b0;
      end else begin
         wb.wen_w <= wb.wen_m;
      end
   end

   always_ff @(posedge clk) begin
      wb.rd_w   <= wb.rd_m;
      wb.data_w <= wb.data_m;
   end

   // register file write port
   assign irf_rd_data_w = wb.data_w;
   assign irf_wen_w     = wb.wen_w;
   assign irf_rd_w      = wb.rd_w;

endmodule

// ==== hw/issue_if.sv ====
interface issue_if import exu_pkg::*; #(
   parameter int grlen = 32
);
   // stage valids and write enables
   logic             valid_e;
   logic             bru_valid_e;
   logic             mul_valid_e;
   logic             alu_wen_e;
   logic             mul_wen_e;

   // source registers and pre-bypass operands
   reg_addr_t        rs1_e;
   reg_addr_t        rs2_e;
   logic             a_sel_rf_e;
   logic             b_sel_rf_e;
   logic [grlen-1:0] alu_a_e;
   logic [grlen-1:0] alu_b_e;

   // unit controls
   alu_code_t        alu_op_e;
   logic [grlen-1:0] alu_c_e;
   logic             double_word_e;
   bru_code_t        bru_op_e;
   logic [grlen-1:0] pc_e;
   logic [grlen-1:0] br_offs_e;
   logic             signed_e;
   logic             double_e;
   logic             hi_e;
   logic             short_e;
   reg_addr_t        rd_e;

   modport dispatch (output valid_e, bru_valid_e, mul_valid_e, alu_wen_e, mul_wen_e,
                     rs1_e, rs2_e, a_sel_rf_e, b_sel_rf_e, alu_a_e, alu_b_e,
                     alu_op_e, alu_c_e, double_word_e, bru_op_e, pc_e, br_offs_e,
                     signed_e, double_e, hi_e, short_e, rd_e);

   modport execute (input valid_e, bru_valid_e, mul_valid_e, alu_wen_e, mul_wen_e,
                    alu_op_e, alu_c_e, double_word_e, bru_op_e, pc_e, br_offs_e,
                    signed_e, double_e, hi_e, short_e, rd_e);

   modport bypass (input rs1_e, rs2_e, a_sel_rf_e, b_sel_rf_e, alu_a_e, alu_b_e);

endinterface

// ==== hw/wb_if.sv ====
interface wb_if import exu_pkg::*; #(
   parameter int grlen = 32
);
   // m stage, combinational result select
   reg_addr_t        rd_m;
   logic             wen_m;
   logic [grlen-1:0] data_m;

   // w stage, registered
   reg_addr_t        rd_w;
   logic             wen_w;
   logic [grlen-1:0] data_w;

   modport writeback (output rd_m, wen_m, data_m, rd_w, wen_w, data_w);

   modport bypass (input rd_m, wen_m, data_m, rd_w, wen_w, data_w);

endinterface

// ==== verif/tb_exu_tasks.svh ====
//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic cmp_data(input string name, input logic [grlen-1:0] exp,
                        input logic [grlen-1:0] act);
   if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
   end
endtask

task automatic cmp_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
   if (act !== exp) begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
   end
endtask

task automatic cmp_code(input string name, input alu_code_t exp, input alu_code_t act);
   if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
   end
endtask

task automatic cmp_bru_code(input string name, input bru_code_t exp, input bru_code_t act);
   if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
   end
endtask

task automatic cmp_bit(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
   end
endtask

//////////////////////////////////////////////////
// drive tasks
//////////////////////////////////////////////////

task automatic clear_inputs();
   valid_d       = 1'b0;
   inst_d        = '0;
   pc_d          = '0;
   imm_d         = '0;
   c_d           = '0;
   br_offs_d     = '0;
   alu_code_d    = '0;
   bru_code_d    = '0;
   mdu_code_d    = '0;
   is_bru_d      = 1'b0;
   is_mul_d      = 1'b0;
   a_pc_d        = 1'b0;
   b_imm_d       = 1'b0;
   rd2rj_d       = 1'b0;
   rd_read_d     = 1'b0;
   double_word_d = 1'b0;
   rf_wen_d      = 1'b0;
   rf_target_d   = '0;
   rs1_data_d    = '0;
   rs2_data_d    = '0;
   alu_res_e     = '0;
   bru_taken_e   = 1'b0;
   bru_target_e  = '0;
   bru_link_pc_e = '0;
   bru_wen_e     = 1'b0;
   mul_res_m     = '0;
endtask

// idle until M and W hold nothing
task automatic drain_pipe();
   clear_inputs();
   repeat (3) @(negedge clk);
endtask

// register-register alu op, rj in [9:5], rk in [14:10]
task automatic issue_alu(input reg_addr_t rj, input reg_addr_t rk, input reg_addr_t rd,
                         input logic wen);
   inst_t       inst;
   logic [31:0] r;
   inst        = next_rand();
   inst[9:5]   = rj;
   inst[14:10] = rk;
   r           = next_rand();
   clear_inputs();
   valid_d       = 1'b1;
   inst_d        = inst;
   pc_d          = next_rand();
   imm_d         = next_rand();
   c_d           = next_rand();
   br_offs_d     = next_rand();
   rs1_data_d    = next_rand();
   rs2_data_d    = next_rand();
   alu_code_d    = r[3:0];
   bru_code_d    = r[7:4];
   double_word_d = r[8];
   rf_wen_d      = wen;
   rf_target_d   = rd;
endtask

// {signed, double, hi, short} per mdu code
function automatic logic [3:0] expected_mul_flags(input mdu_code_t code);
   case (code)
      4'd0:    return 4'b1001;
      4'd1:    return 4'b1011;
      4'd2:    return 4'b0011;
      4'd3:    return 4'b1100;
      4'd4:    return 4'b1110;
      4'd5:    return 4'b0110;
      4'd6:    return 4'b1000;
      default: return 4'b0000;
   endcase
endfunction

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic alu_reg_test();
   logic [31:0]      r;
   logic [grlen-1:0] exp_a;
   logic [grlen-1:0] exp_b;
   logic [grlen-1:0] exp_c;
   logic [grlen-1:0] res;
   alu_code_t        exp_op;
   reg_addr_t        exp_rd;
   logic             exp_dw;
   drain_pipe();
   r = next_rand();
   issue_alu(r[4:0], r[9:5], r[14:10], 1'b1);
   #1;
   cmp_addr("alu_reg rs1 from rj", r[4:0], rs1_d);
   cmp_addr("alu_reg rs2 from rk", r[9:5], rs2_d);
   rd2rj_d   = 1'b1;
   rd_read_d = 1'b1;
   #1;
   cmp_addr("alu_reg rs1 from rd", inst_d[4:0], rs1_d);
   cmp_addr("alu_reg rs2 from rd", inst_d[4:0], rs2_d);
   rd2rj_d   = 1'b0;
   rd_read_d = 1'b0;
   exp_a  = rs1_data_d;
   exp_b  = rs2_data_d;
   exp_c  = c_d;
   exp_op = alu_code_d;
   exp_rd = rf_target_d;
   exp_dw = double_word_d;
   @(negedge clk);
   cmp_bit("alu_reg valid", 1'b1, alu_valid_e);
   cmp_data("alu_reg a", exp_a, alu_a_e);
   cmp_data("alu_reg b", exp_b, alu_b_e);
   cmp_data("alu_reg c", exp_c, alu_c_e);
   cmp_code("alu_reg op", exp_op, alu_op_e);
   cmp_bit("alu_reg double_word", exp_dw, alu_double_word_e);
   clear_inputs();
   res       = next_rand();
   alu_res_e = res;
   @(negedge clk);
   @(negedge clk);
   cmp_bit("alu_reg wen", 1'b1, irf_wen_w);
   cmp_addr("alu_reg rd", exp_rd, irf_rd_w);
   cmp_data("alu_reg data", res, irf_rd_data_w);
   // same op without a register write
   issue_alu(r[4:0], r[9:5], r[14:10], 1'b0);
   @(negedge clk);
   clear_inputs();
   alu_res_e = next_rand();
   @(negedge clk);
   @(negedge clk);
   cmp_bit("alu_reg no write", 1'b0, irf_wen_w);
endtask

task automatic operand_sel_test();
   logic [grlen-1:0] exp_a;
   logic [grlen-1:0] exp_b;
   logic [grlen-1:0] res;
   drain_pipe();
   issue_alu(5'd5, 5'd6, 5'd5, 1'b1);
   @(negedge clk);
   res = next_rand();
   // reads r5 twice while the previous op writes r5
   issue_alu(5'd5, 5'd5, 5'd6, 1'b1);
   a_pc_d    = 1'b1;
   b_imm_d   = 1'b1;
   exp_a     = pc_d;
   exp_b     = imm_d;
   alu_res_e = res;
   @(negedge clk);
   cmp_data("operand_sel pc", exp_a, alu_a_e);
   cmp_data("operand_sel imm", exp_b, alu_b_e);
   clear_inputs();
endtask

task automatic forwarding_test();
   logic [grlen-1:0] res [1:5];
   logic [grlen-1:0] exp_a;
   logic [grlen-1:0] exp_b;
   drain_pipe();
   issue_alu(5'd0, 5'd0, 5'd7, 1'b1);
   @(negedge clk);
   res[1] = next_rand();
   issue_alu(5'd7, 5'd7, 5'd9, 1'b1);
   alu_res_e = res[1];
   @(negedge clk);
   cmp_data("forward from m", res[1], alu_a_e);
   cmp_data("forward b from m", res[1], alu_b_e);
   res[2] = next_rand();
   issue_alu(5'd7, 5'd7, 5'd7, 1'b1);
   alu_res_e = res[2];
   @(negedge clk);
   cmp_data("forward from w", res[1], alu_a_e);
   cmp_data("forward b from w", res[1], alu_b_e);
   res[3] = next_rand();
   issue_alu(5'd7, 5'd0, 5'd7, 1'b1);
   alu_res_e = res[3];
   @(negedge clk);
   cmp_data("forward from m again", res[3], alu_a_e);
   res[4] = next_rand();
   issue_alu(5'd7, 5'd0, 5'd0, 1'b1);
   alu_res_e = res[4];
   @(negedge clk);
   // both later stages hold r7 here
   cmp_data("forward m over w", res[4], alu_a_e);
   res[5] = next_rand();
   issue_alu(5'd0, 5'd0, 5'd10, 1'b1);
   exp_a     = rs1_data_d;
   exp_b     = rs2_data_d;
   alu_res_e = res[5];
   @(negedge clk);
   cmp_data("no forward of r0", exp_a, alu_a_e);
   cmp_data("no forward of r0 b", exp_b, alu_b_e);
   clear_inputs();
endtask

task automatic branch_test();
   logic [grlen-1:0] tgt;
   logic [grlen-1:0] link;
   logic [grlen-1:0] res;
   logic [grlen-1:0] exp_a;
   logic [grlen-1:0] exp_b;
   logic [grlen-1:0] exp_pc;
   logic [grlen-1:0] exp_offs;
   bru_code_t        exp_op;
   drain_pipe();
   issue_alu(5'd1, 5'd2, 5'd11, 1'b0);
   is_bru_d = 1'b1;
   // immediate select applies to alu ops only
   b_imm_d  = 1'b1;
   exp_a    = rs1_data_d;
   exp_b    = rs2_data_d;
   exp_pc   = pc_d;
   exp_offs = br_offs_d;
   exp_op   = bru_code_d;
   @(negedge clk);
   cmp_bit("branch bru_valid", 1'b1, bru_valid_e);
   cmp_bru_code("branch op", exp_op, bru_op_e);
   cmp_data("branch a", exp_a, bru_a_e);
   cmp_data("branch b", exp_b, bru_b_e);
   cmp_data("branch pc", exp_pc, bru_pc_e);
   cmp_data("branch offset", exp_offs, bru_offset_e);
   // this op sits in D while the branch resolves
   issue_alu(5'd1, 5'd2, 5'd12, 1'b1);
   tgt           = next_rand();
   link          = next_rand();
   bru_taken_e   = 1'b1;
   bru_target_e  = tgt;
   bru_link_pc_e = link;
   bru_wen_e     = 1'b1;
   alu_res_e     = next_rand();
   #1;
   cmp_bit("branch taken", 1'b1, br_taken);
   cmp_data("branch target", tgt, br_target);
   @(negedge clk);
   cmp_bit("branch killed alu_valid", 1'b0, alu_valid_e);
   clear_inputs();
   @(negedge clk);
   cmp_bit("branch link wen", 1'b1, irf_wen_w);
   cmp_addr("branch link rd", 5'd11, irf_rd_w);
   cmp_data("branch link data", link, irf_rd_data_w);
   @(negedge clk);
   cmp_bit("branch killed wen", 1'b0, irf_wen_w);
   // not taken, no link write
   issue_alu(5'd3, 5'd4, 5'd13, 1'b0);
   is_bru_d = 1'b1;
   @(negedge clk);
   issue_alu(5'd0, 5'd0, 5'd14, 1'b1);
   #1;
   cmp_bit("branch not taken", 1'b0, br_taken);
   @(negedge clk);
   cmp_bit("not taken alu_valid", 1'b1, alu_valid_e);
   clear_inputs();
   res       = next_rand();
   alu_res_e = res;
   @(negedge clk);
   cmp_bit("not taken branch wen", 1'b0, irf_wen_w);
   @(negedge clk);
   cmp_bit("not taken alu wen", 1'b1, irf_wen_w);
   cmp_addr("not taken alu rd", 5'd14, irf_rd_w);
   cmp_data("not taken alu data", res, irf_rd_data_w);
endtask

task automatic multiply_test();
   int               i;
   logic [31:0]      r;
   logic [3:0]       flags;
   logic [grlen-1:0] res;
   logic [grlen-1:0] exp_a;
   logic [grlen-1:0] exp_b;
   mdu_code_t        code;
   reg_addr_t        rd;
   drain_pipe();
   for (i = 0; i < 8; i++) begin
      code  = i[3:0];
      flags = expected_mul_flags(code);
      r     = next_rand();
      rd    = r[4:0] | 5'd1;
      issue_alu(r[9:5], r[14:10], rd, 1'b1);
      is_mul_d   = 1'b1;
      mdu_code_d = code;
      exp_a      = rs1_data_d;
      exp_b      = rs2_data_d;
      @(negedge clk);
      cmp_bit($sformatf("mul %0d valid", i), 1'b1, mul_valid_e);
      cmp_bit($sformatf("mul %0d signed", i), flags[3], mul_signed_e);
      cmp_bit($sformatf("mul %0d double", i), flags[2], mul_double_e);
      cmp_bit($sformatf("mul %0d hi", i), flags[1], mul_hi_e);
      cmp_bit($sformatf("mul %0d short", i), flags[0], mul_short_e);
      cmp_data($sformatf("mul %0d a", i), exp_a, mul_a_e);
      cmp_data($sformatf("mul %0d b", i), exp_b, mul_b_e);
      clear_inputs();
      // stray alu result, must lose to the product
      alu_res_e = next_rand();
      @(negedge clk);
      res       = next_rand();
      mul_res_m = res;
      @(negedge clk);
      cmp_bit($sformatf("mul %0d wen", i), 1'b1, irf_wen_w);
      cmp_addr($sformatf("mul %0d rd", i), rd, irf_rd_w);
      cmp_data($sformatf("mul %0d data", i), res, irf_rd_data_w);
   end
   clear_inputs();
endtask

// ==== verif/tb_exu_ecl.sv ====
module tb_exu_ecl import exu_pkg::*; ();

   localparam int grlen     = 32;
   localparam int num_tests = 5;
   // generous budget per directed test plus the reset cycles
   localparam int max_cycles = num_tests * 40 + 3;

   logic             clk;
   logic             reset;

   // decoded instruction in D
   logic             valid_d;
   inst_t            inst_d;
   logic [grlen-1:0] pc_d;
   logic [grlen-1:0] imm_d;
   logic [grlen-1:0] c_d;
   logic [grlen-1:0] br_offs_d;
   alu_code_t        alu_code_d;
   bru_code_t        bru_code_d;
   mdu_code_t        mdu_code_d;
   logic             is_bru_d;
   logic             is_mul_d;
   logic             a_pc_d;
   logic             b_imm_d;
   logic             rd2rj_d;
   logic             rd_read_d;
   logic             double_word_d;
   logic             rf_wen_d;
   reg_addr_t        rf_target_d;
   reg_addr_t        rs1_d;
   reg_addr_t        rs2_d;
   logic [grlen-1:0] rs1_data_d;
   logic [grlen-1:0] rs2_data_d;

   // alu
   logic             alu_valid_e;
   logic [grlen-1:0] alu_a_e;
   logic [grlen-1:0] alu_b_e;
   alu_code_t        alu_op_e;
   logic [grlen-1:0] alu_c_e;
   logic             alu_double_word_e;
   logic [grlen-1:0] alu_res_e;

   // branch unit
   logic             bru_valid_e;
   bru_code_t        bru_op_e;
   logic [grlen-1:0] bru_a_e;
   logic [grlen-1:0] bru_b_e;
   logic [grlen-1:0] bru_pc_e;
   logic [grlen-1:0] bru_offset_e;
   logic             bru_taken_e;
   logic [grlen-1:0] bru_target_e;
   logic [grlen-1:0] bru_link_pc_e;
   logic             bru_wen_e;
   logic             br_taken;
   logic [grlen-1:0] br_target;

   // multiplier
   logic             mul_valid_e;
   logic [grlen-1:0] mul_a_e;
   logic [grlen-1:0] mul_b_e;
   logic             mul_signed_e;
   logic             mul_double_e;
   logic             mul_hi_e;
   logic             mul_short_e;
   logic [grlen-1:0] mul_res_m;

   // register file write port
   logic [grlen-1:0] irf_rd_data_w;
   logic             irf_wen_w;
   reg_addr_t        irf_rd_w;

   logic [31:0]      rng_state = 32'h1286_5be5;

   exu_ecl #(.grlen(grlen)) dut_i (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // xorshift32 stream for data and instruction words
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   `include "tb_exu_tasks.svh"

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      clear_inputs();
      reset = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      // nothing in flight straight out of reset
      cmp_bit("reset alu_valid_e", 1'b0, alu_valid_e);
      cmp_bit("reset bru_valid_e", 1'b0, bru_valid_e);
      cmp_bit("reset mul_valid_e", 1'b0, mul_valid_e);
      cmp_bit("reset br_taken", 1'b0, br_taken);
      cmp_bit("reset irf_wen_w", 1'b0, irf_wen_w);

      alu_reg_test();
      operand_sel_test();
      forwarding_test();
      branch_test();
      multiply_test();

      $display("Done: no errors");
      $finish;
   end

   // watchdog
   initial begin
      repeat (max_cycles) @(posedge clk);
      $display("timeout: the test sequence did not finish in %0d cycles", max_cycles);
      $display("Done: errors found");
      $fatal(1);
   end

endmodule
